/* vlog.f */
hw/mem_pkg.sv
hw/store_format.sv
hw/load_format.sv
hw/dtim.sv
hw/memory_stage.sv
hw/mem_subsystem.sv
tests/mem_subsystem_properties.sv
tests/mem_subsystem_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
TOP ?= mem_subsystem_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FAIL_TEXT = Verification failed
PASS_TEXT = Verification passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BINARY)
	-./$(BINARY) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG) || ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/mem_subsystem_tb.sv */
`default_nettype none

module mem_subsystem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import mem_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int NUM_ENTRIES = 36;

  typedef struct {
    mem_op_t op;
    mem_size_t size;
    logic is_unsigned;
    logic [31:0] address;
    logic [31:0] sdata;
    logic [REG_ADDR_BITS-1:0] waddr;
    logic wren;
    logic [XLEN-1:0] alu_data;
    logic clear_flag;
  } entry_t;

  logic clock;
  logic reset;
  logic clear;
  logic e_valid;
  mem_op_t e_op;
  mem_size_t e_size;
  logic e_unsigned;
  logic [31:0] e_address;
  logic [31:0] e_sdata;
  logic [REG_ADDR_BITS-1:0] e_waddr;
  logic e_wren;
  logic [XLEN-1:0] e_wdata;
  logic [31:0] e_pc;
  logic stall;
  logic fwd_wren;
  logic [REG_ADDR_BITS-1:0] fwd_waddr;
  logic [XLEN-1:0] fwd_wdata;
  logic wb_valid;
  logic wb_wren;
  logic [REG_ADDR_BITS-1:0] wb_waddr;
  logic [XLEN-1:0] wb_wdata;
  logic exc_valid;
  logic [3:0] exc_cause;
  logic [31:0] exc_tval;
  logic [31:0] exc_epc;

  entry_t entries [NUM_ENTRIES];
  int entry_count = 0;
  integer seed = 32'h2f27_f6a5;
  logic [7:0] ref_mem [DTIM_DEPTH*4]; // byte image of the data memory
  int unsigned property_failures;

  assign property_failures =
    mem_subsystem_inst.memory_stage_inst.mem_subsystem_properties_inst.failure_count;

  mem_subsystem mem_subsystem_inst (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    repeat (RESET_CYCLES + 40 * NUM_ENTRIES) @(posedge clock);
    $display("Timeout: the stimulus table did not complete in the expected time");
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    assert (actual === expected) else begin
      $display("Fail at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
      $display("Verification failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic add_entry(input mem_op_t op, input mem_size_t size, input logic is_unsigned,
                           input logic [31:0] address, input logic wren, input logic clear_flag);
    entry_t e;
    e.op = op;
    e.size = size;
    e.is_unsigned = is_unsigned;
    e.address = address;
    e.sdata = $random(seed);
    e.waddr = REG_ADDR_BITS'(entry_count % 31 + 1); // never x0
    e.wren = wren;
    e.alu_data = $random(seed);
    e.clear_flag = clear_flag;
    entries[entry_count] = e;
    entry_count++;
  endtask

  task automatic build_table();
    add_entry(op_store, size_word, 1'b0, 32'h000, 1'b0, 1'b0);
    add_entry(op_store, size_word, 1'b0, 32'h004, 1'b0, 1'b0);
    add_entry(op_store, size_word, 1'b0, 32'h3fc, 1'b0, 1'b0);
    add_entry(op_load, size_word, 1'b0, 32'h000, 1'b1, 1'b0);
    add_entry(op_load, size_word, 1'b0, 32'h004, 1'b1, 1'b0);
    add_entry(op_load, size_word, 1'b0, 32'h3fc, 1'b1, 1'b0);
    for (int k = 0; k < 4; k++) begin
      add_entry(op_load, size_byte, 1'b0, 32'h000 + 32'(k), 1'b1, 1'b0);
      add_entry(op_load, size_byte, 1'b1, 32'h3fc + 32'(k), 1'b1, 1'b0);
    end
    add_entry(op_load, size_half, 1'b0, 32'h000, 1'b1, 1'b0);
    add_entry(op_load, size_half, 1'b0, 32'h002, 1'b1, 1'b0);
    add_entry(op_load, size_half, 1'b1, 32'h3fc, 1'b1, 1'b0);
    add_entry(op_load, size_half, 1'b1, 32'h3fe, 1'b1, 1'b0);
    add_entry(op_store, size_word, 1'b0, 32'h008, 1'b0, 1'b0);
    add_entry(op_store, size_byte, 1'b0, 32'h00b, 1'b0, 1'b0);
    add_entry(op_store, size_half, 1'b0, 32'h008, 1'b0, 1'b0);
    add_entry(op_store, size_byte, 1'b0, 32'h005, 1'b0, 1'b0);
    add_entry(op_store, size_half, 1'b0, 32'h006, 1'b0, 1'b0);
    add_entry(op_load, size_word, 1'b0, 32'h008, 1'b1, 1'b0);
    add_entry(op_load, size_word, 1'b0, 32'h004, 1'b1, 1'b0);
    add_entry(op_load, size_half, 1'b0, 32'h001, 1'b1, 1'b0); // misaligned from here
    add_entry(op_load, size_word, 1'b0, 32'h002, 1'b1, 1'b0);
    add_entry(op_store, size_half, 1'b0, 32'h003, 1'b0, 1'b0);
    add_entry(op_store, size_word, 1'b0, 32'h005, 1'b0, 1'b0);
    add_entry(op_load, size_word, 1'b0, 32'h004, 1'b1, 1'b0);
    add_entry(op_alu, size_word, 1'b0, 32'h000, 1'b1, 1'b0);
    add_entry(op_alu, size_word, 1'b0, 32'h000, 1'b0, 1'b0);
    add_entry(op_fence, size_word, 1'b0, 32'h000, 1'b0, 1'b0);
    add_entry(op_alu, size_word, 1'b0, 32'h000, 1'b1, 1'b0);
    add_entry(op_load, size_word, 1'b0, 32'h000, 1'b1, 1'b1); // flushed while stalled
    add_entry(op_load, size_word, 1'b0, 32'h000, 1'b1, 1'b0);
  endtask

  function automatic logic [31:0] expected_load(input entry_t e);
    logic [9:0] base;
    logic [31:0] value;
    base = e.address[9:0];
    value = {ref_mem[base + 10'd3], ref_mem[base + 10'd2], ref_mem[base + 10'd1], ref_mem[base]};
    case (e.size)
      size_byte: return e.is_unsigned ? {24'h0, value[7:0]} : {{24{value[7]}}, value[7:0]};
      size_half: return e.is_unsigned ? {16'h0, value[15:0]} : {{16{value[15]}}, value[15:0]};
      default: return value;
    endcase
  endfunction

  task automatic update_ref(input entry_t e);
    int count;
    count = (e.size == size_byte) ? 1 : (e.size == size_half) ? 2 : 4;
    for (int k = 0; k < count; k++) begin
      ref_mem[e.address[9:0] + 10'(k)] = e.sdata[8*k +: 8];
    end
  endtask

  task automatic apply_entry(input int i);
    entry_t e;
    logic bad;
    logic [31:0] load_value;
    int stall_cycles;
    e = entries[i];
    bad = (e.op inside {op_load, op_store}) &&
          ((e.size == size_half && e.address[0]) || (e.size == size_word && e.address[1:0] != 0));
    load_value = expected_load(e);
    e_valid = 1'b1;
    e_op = e.op;
    e_size = e.size;
    e_unsigned = e.is_unsigned;
    e_address = e.address;
    e_sdata = e.sdata;
    e_waddr = e.waddr;
    e_wren = e.wren;
    e_wdata = e.alu_data;
    e_pc = 32'h0000_1000 + 32'(4 * i);
    #1;
    if (e.clear_flag) begin
      check_value("stall", stall, 1'b1);
      @(negedge clock);
      clear = 1'b1;
      #1;
      check_value("stall", stall, 1'b0);
      @(negedge clock);
      clear = 1'b0;
      check_value("wb_valid", wb_valid, 1'b0);
      check_value("exc_valid", exc_valid, 1'b0);
    end else begin
      stall_cycles = 0;
      while (stall) begin
        stall_cycles++;
        @(negedge clock);
        #1;
      end
      check_value("stall cycles", stall_cycles, (e.op == op_alu || bad) ? 0 : DTIM_WAIT_CYCLES);
      if (e.op == op_alu || (e.op == op_load && !bad)) begin
        check_value("fwd_wren", fwd_wren, e.wren);
        check_value("fwd_waddr", fwd_waddr, e.waddr);
        check_value("fwd_wdata", fwd_wdata, (e.op == op_load) ? load_value : e.alu_data);
      end
      @(negedge clock);
      check_value("exc_valid", exc_valid, bad);
      check_value("wb_valid", wb_valid, !bad);
      if (bad) begin
        check_value("exc_cause", exc_cause,
                    (e.op == op_store) ? CAUSE_STORE_MISALIGNED : CAUSE_LOAD_MISALIGNED);
        check_value("exc_tval", exc_tval, e.address);
        check_value("exc_epc", exc_epc, e_pc);
      end else begin
        check_value("wb_wren", wb_wren, e.wren);
        check_value("wb_waddr", wb_waddr, e.waddr);
        if (e.wren) begin
          check_value("wb_wdata", wb_wdata, (e.op == op_load) ? load_value : e.alu_data);
        end
        if (e.op == op_store) begin
          update_ref(e);
        end
      end
    end
  endtask

  initial begin
    reset = 1'b0;
    clear = 1'b0;
    e_valid = 1'b0;
    e_op = op_alu;
    e_size = size_word;
    e_unsigned = 1'b0;
    e_address = '0;
    e_sdata = '0;
    e_waddr = '0;
    e_wren = 1'b0;
    e_wdata = '0;
    e_pc = '0;
    build_table();
    repeat (RESET_CYCLES) @(negedge clock);
    reset = 1'b1;
    check_value("wb_valid", wb_valid, 1'b0);
    check_value("exc_valid", exc_valid, 1'b0);
    check_value("stall", stall, 1'b0);
    for (int i = 0; i < entry_count; i++) begin
      apply_entry(i);
    end
    e_valid = 1'b0;
    @(negedge clock);
    if (property_failures == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Concurrent assertions in the memory stage failed %0d times", property_failures);
      $display("Verification failed");
      $fatal(1, "assertion failures");
    end
  end

endmodule

`default_nettype wire

/* tests/mem_subsystem_properties.sv */
`default_nettype none

module mem_subsystem_properties (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic mem_valid,
  input logic mem_ready,
  input logic mem_write,
  input logic [31:0] mem_addr,
  input logic stall
);

  timeunit 1ns;
  timeprecision 1ps;

  import mem_pkg::*;

  int unsigned request_failures = 0;
  int unsigned clear_failures = 0;
  int unsigned wait_failures = 0;
  int unsigned failure_count;

  assign failure_count = request_failures + clear_failures + wait_failures;

  // only a flush may withdraw a request before the memory answers
  request_held: assert property (@(posedge clock) disable iff (!reset)
    mem_valid && !mem_ready |=> clear || (mem_valid && $stable(mem_addr) && $stable(mem_write)))
  else begin
    $error("memory request changed before it was acknowledged");
    request_failures++;
  end

  // a flush empties the wait counter so the memory cannot answer in the next cycle
  restart_after_clear: assert property (@(posedge clock) disable iff (!reset)
    clear |=> !mem_ready)
  else begin
    $error("memory answered right after a pipeline flush");
    clear_failures++;
  end

  // a new request is answered once the wait states have passed
  ready_after_wait: assert property (@(posedge clock) disable iff (!reset || clear)
    mem_valid && !$past(stall) |-> ##(DTIM_WAIT_CYCLES) mem_ready)
  else begin
    $error("memory did not answer after the wait states");
    wait_failures++;
  end

endmodule

bind memory_stage mem_subsystem_properties mem_subsystem_properties_inst (.*);

`default_nettype wire

/* hw/mem_subsystem.sv */
`default_nettype none

module mem_subsystem (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic e_valid,
  input mem_pkg::mem_op_t e_op,
  input mem_pkg::mem_size_t e_size,
  input logic e_unsigned,
  input logic [31:0] e_address,
  input logic [31:0] e_sdata,
  input logic [mem_pkg::REG_ADDR_BITS-1:0] e_waddr,
  input logic e_wren,
  input logic [mem_pkg::XLEN-1:0] e_wdata,
  input logic [31:0] e_pc,
  output logic stall,
  output logic fwd_wren,
  output logic [mem_pkg::REG_ADDR_BITS-1:0] fwd_waddr,
  output logic [mem_pkg::XLEN-1:0] fwd_wdata,
  output logic wb_valid,
  output logic wb_wren,
  output logic [mem_pkg::REG_ADDR_BITS-1:0] wb_waddr,
  output logic [mem_pkg::XLEN-1:0] wb_wdata,
  output logic exc_valid,
  output logic [3:0] exc_cause,
  output logic [31:0] exc_tval,
  output logic [31:0] exc_epc
);

  import mem_pkg::*;

  logic [31:0] st_wdata;
  logic [3:0] st_wstrb;
  logic st_misaligned;
  logic [31:0] ld_data;
  logic mem_valid;
  logic mem_write;
  logic mem_fence;
  logic mem_ready;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0] mem_wstrb;
  mem_word_t mem_rdata;

  store_format store_format_inst (
    .size(e_size),
    .address(e_address),
    .sdata(e_sdata),
    .wdata(st_wdata),
    .wstrb(st_wstrb),
    .misaligned(st_misaligned)
  );

  load_format load_format_inst (
    .rdata(mem_rdata),
    .size(e_size),
    .unsigned_load(e_unsigned),
    .offset(e_address[1:0]),
    .ldata(ld_data)
  );

  memory_stage memory_stage_inst (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .e_valid(e_valid),
    .e_op(e_op),
    .e_size(e_size),
    .e_unsigned(e_unsigned),
    .e_address(e_address),
    .e_waddr(e_waddr),
    .e_wren(e_wren),
    .e_wdata(e_wdata),
    .e_pc(e_pc),
    .st_wdata(st_wdata),
    .st_wstrb(st_wstrb),
    .st_misaligned(st_misaligned),
    .ld_data(ld_data),
    .mem_ready(mem_ready),
    .mem_valid(mem_valid),
    .mem_write(mem_write),
    .mem_fence(mem_fence),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .stall(stall),
    .fwd_wren(fwd_wren),
    .fwd_waddr(fwd_waddr),
    .fwd_wdata(fwd_wdata),
    .wb_valid(wb_valid),
    .wb_wren(wb_wren),
    .wb_waddr(wb_waddr),
    .wb_wdata(wb_wdata),
    .exc_valid(exc_valid),
    .exc_cause(exc_cause),
    .exc_tval(exc_tval),
    .exc_epc(exc_epc)
  );

  dtim dtim_inst (
    .clock(clock),
    .reset(reset),
    .mem_valid(mem_valid),
    .mem_write(mem_write),
    .mem_fence(mem_fence),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_ready(mem_ready),
    .mem_rdata(mem_rdata)
  );

endmodule

`default_nettype wire

/* hw/memory_stage.sv */
`default_nettype none

module memory_stage (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic e_valid,
  input mem_pkg::mem_op_t e_op,
  input mem_pkg::mem_size_t e_size,
  input logic e_unsigned,
  input logic [31:0] e_address,
  input logic [mem_pkg::REG_ADDR_BITS-1:0] e_waddr,
  input logic e_wren,
  input logic [mem_pkg::XLEN-1:0] e_wdata,
  input logic [31:0] e_pc,
  input logic [31:0] st_wdata,
  input logic [3:0] st_wstrb,
  input logic st_misaligned,
  input logic [31:0] ld_data,
  input logic mem_ready,
  output logic mem_valid,
  output logic mem_write,
  output logic mem_fence,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata,
  output logic [3:0] mem_wstrb,
  output logic stall,
  output logic fwd_wren,
  output logic [mem_pkg::REG_ADDR_BITS-1:0] fwd_waddr,
  output logic [mem_pkg::XLEN-1:0] fwd_wdata,
  output logic wb_valid,
  output logic wb_wren,
  output logic [mem_pkg::REG_ADDR_BITS-1:0] wb_waddr,
  output logic [mem_pkg::XLEN-1:0] wb_wdata,
  output logic exc_valid,
  output logic [3:0] exc_cause,
  output logic [31:0] exc_tval,
  output logic [31:0] exc_epc
);

  import mem_pkg::*;

  logic is_load;
  logic is_store;
  logic is_fence;
  logic bad_encoding;
  logic misaligned;
  logic access;
  logic wren;
  logic [XLEN-1:0] result;
  logic next_valid;
  logic next_exception;

  assign is_load = e_valid && (e_op == op_load);
  assign is_store = e_valid && (e_op == op_store);
  assign is_fence = e_valid && (e_op == op_fence);

  // an undefined size, an unsigned store or an unsigned word load has no
  // legal alignment and traps the same way
  assign bad_encoding = !(e_size inside {size_byte, size_half, size_word}) ||
                        (e_unsigned && (e_op == op_store || e_size == size_word));

  assign misaligned = (is_load | is_store) & (st_misaligned | bad_encoding);

  assign access = (is_load | is_store | is_fence) & ~misaligned;

  assign mem_valid = access & ~clear; // a flush withdraws the request and restarts the wait
  assign mem_write = is_store;
  assign mem_fence = is_fence;
  assign mem_addr = e_address;
  assign mem_wdata = st_wdata;
  assign mem_wstrb = is_store ? st_wstrb : 4'b0000;

  assign stall = access & ~mem_ready & ~clear;

  assign result = is_load ? ld_data : e_wdata;

  assign wren = e_valid & e_wren & ~misaligned;

  // load data is only meaningful in the ready cycle
  assign fwd_wren = wren & ~stall;
  assign fwd_waddr = e_waddr;
  assign fwd_wdata = result;

  assign next_valid = e_valid & ~misaligned & ~stall & ~clear;

  assign next_exception = misaligned & ~clear;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      wb_valid <= 1'b0;
      wb_wren <= 1'b0;
      exc_valid <= 1'b0;
    end else begin
      wb_valid <= next_valid;
      wb_wren <= next_valid & wren;
      exc_valid <= next_exception;
    end
  end

  always_ff @(posedge clock) begin
    wb_waddr <= e_waddr;
    wb_wdata <= result;
    exc_cause <= is_store ? CAUSE_STORE_MISALIGNED : CAUSE_LOAD_MISALIGNED;
    exc_tval <= e_address;
    exc_epc <= e_pc;
  end

endmodule

`default_nettype wire

/* hw/dtim.sv */
`default_nettype none

module dtim (
  input logic clock,
  input logic reset,
  input logic mem_valid,
  input logic mem_write,
  input logic mem_fence,
  input logic [31:0] mem_addr,
  input logic [31:0] mem_wdata,
  input logic [3:0] mem_wstrb,
  output logic mem_ready,
  output mem_pkg::mem_word_t mem_rdata
);

  import mem_pkg::*;

  logic [XLEN-1:0] storage [DTIM_DEPTH];

  logic [DTIM_ADDR_BITS-1:0] index;

  logic [DTIM_WAIT_BITS-1:0] wait_count;

  logic write_enable;

  assign index = mem_addr[DTIM_ADDR_BITS+1:2];

  // ready comes straight from the counter once the wait states have passed
  assign mem_ready = mem_valid && (wait_count == DTIM_WAIT_BITS'(DTIM_WAIT_CYCLES));

  // a fence only waits for the acknowledge and never touches the array
  assign write_enable = mem_ready & mem_write & ~mem_fence;

  assign mem_rdata.word = storage[index];

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      wait_count <= '0;
    end else if (!mem_valid || mem_ready) begin
      wait_count <= '0; // a dropped request restarts the wait
    end else begin
      wait_count <= wait_count + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (write_enable) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (mem_wstrb[lane]) begin
          storage[index][8*lane +: 8] <= mem_wdata[8*lane +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/load_format.sv */
`default_nettype none

module load_format (
  input mem_pkg::mem_word_t rdata,
  input mem_pkg::mem_size_t size,
  input logic unsigned_load,
  input logic [1:0] offset,
  output logic [31:0] ldata
);

  import mem_pkg::*;

  logic [7:0] byte_lane;
  logic [15:0] half_lane;
  logic byte_sign;
  logic half_sign;

  assign byte_lane = rdata.bytes[offset];

  assign half_lane = rdata.halves[offset[1]]; // offset[0] is zero for a legal halfword

  assign byte_sign = byte_lane[7] & ~unsigned_load;

  assign half_sign = half_lane[15] & ~unsigned_load;

  always_comb begin
    case (size)
      size_byte: begin
        ldata = {{24{byte_sign}}, byte_lane};
      end
      size_half: begin
        ldata = {{16{half_sign}}, half_lane};
      end
      default: begin
        ldata = rdata.word;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/store_format.sv */
`default_nettype none

module store_format (
  input mem_pkg::mem_size_t size,
  input logic [31:0] address,
  input logic [31:0] sdata,
  output logic [31:0] wdata,
  output logic [3:0] wstrb,
  output logic misaligned
);

  import mem_pkg::*;

  logic [1:0] offset;

  assign offset = address[1:0];

  always_comb begin
    case (size)
      size_byte: begin
        wdata = {4{sdata[7:0]}}; // every lane carries the byte, the strobe picks one
        wstrb = 4'b0001 << offset;
        misaligned = 1'b0;
      end
      size_half: begin
        wdata = {2{sdata[15:0]}};
        wstrb = offset[1] ? 4'b1100 : 4'b0011;
        misaligned = offset[0];
      end
      size_word: begin
        wdata = sdata;
        wstrb = 4'b1111;
        misaligned = |offset;
      end
      default: begin
        wdata = sdata;
        wstrb = 4'b0000;
        misaligned = 1'b0; // undefined sizes are caught by the stage
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  localparam int XLEN = 32;

  localparam int REG_ADDR_BITS = 5;

  localparam int DTIM_DEPTH = 256;

  localparam int DTIM_ADDR_BITS = 8; // word index taken from address bits 9..2

  localparam int DTIM_WAIT_CYCLES = 2; // wait states before the memory answers

  localparam int DTIM_WAIT_BITS = $clog2(DTIM_WAIT_CYCLES + 1);

  localparam logic [3:0] CAUSE_LOAD_MISALIGNED = 4'd4;

  localparam logic [3:0] CAUSE_STORE_MISALIGNED = 4'd6;

  typedef enum logic [1:0] {
    op_alu = 2'd0,
    op_load = 2'd1,
    op_store = 2'd2,
    op_fence = 2'd3
  } mem_op_t;

  // encoding 2'd3 is unused and treated as an illegal access size
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } mem_size_t;

  // the read word is picked apart either byte by byte or halfword by halfword
  typedef union packed {
    logic [XLEN-1:0] word;
    logic [3:0][7:0] bytes;
    logic [1:0][15:0] halves;
  } mem_word_t;

endpackage

`default_nettype wire
